// ==== hdl/biu_pkg.sv ====
`default_nettype none

package biu_pkg;

	// ==========================================================================
	// widths and sizes
	// ==========================================================================

	localparam int ADR_W = 32;    // byte address
	localparam int DAT_W = 64;    // one bus word
	localparam int SEL_W = 8;     // one select per byte lane
	localparam int TID_W = 4;     // transaction tag from the cpu

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // must hold FIFO_DEPTH itself

	// ==========================================================================
	// codes
	// ==========================================================================

	// request function
	// code 2'b11 has no name and is faulted by the sequencer
	typedef enum logic [1:0] {
		MR_LOAD  = 2'b00,    // sign extending load
		MR_LOADZ = 2'b01,    // zero extending load
		MR_STORE = 2'b10
	} mem_func_t;

	// access size, naturally aligned
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'b00,    // 8 bits
		SZ_WYDE  = 2'b01,    // 16 bits
		SZ_TETRA = 2'b10,    // 32 bits
		SZ_OCTA  = 2'b11     // whole bus word
	} mem_size_t;

	// fault cause returned in the response
	typedef enum logic [1:0] {
		FLT_NONE = 2'b00,
		FLT_SGB  = 2'b01,    // segment bounds
		FLT_UNK  = 2'b10     // unknown function
	} fault_t;

	// ==========================================================================
	// records
	// ==========================================================================

	// cpu to biu
	typedef struct packed {
		mem_func_t          func;
		mem_size_t          size;
		logic [TID_W-1:0]   tid;
		logic [ADR_W-1:0]   adr;    // low bits below the size are ignored
		logic [DAT_W-1:0]   dat;    // store data, right justified
	} mem_req_t;

	// biu to cpu
	typedef struct packed {
		logic [TID_W-1:0]   tid;
		fault_t             cause;
		logic [DAT_W-1:0]   res;        // extended load data, zero otherwise
		logic [ADR_W-1:0]   bad_adr;    // faulting address
	} mem_resp_t;

	// bus master outputs
	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic               we;
		logic [SEL_W-1:0]   sel;
		logic [ADR_W-1:0]   adr;    // word aligned
		logic [DAT_W-1:0]   dat;    // store data already in its lanes
	} bus_out_t;

endpackage

`default_nettype wire

// ==== hdl/biu_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module biu_fifo #(
	parameter type T = biu_pkg::mem_req_t
) (
	input  logic clk,
	input  logic rst,
	input  logic wr_i,       // write strobe
	input  T     din_i,
	input  logic rd_i,       // pop strobe
	output T     dout_o,     // head entry, valid while not empty
	output logic full_o,
	output logic empty_o
);
	import biu_pkg::*;

	// ==========================================================================
	// storage and pointers
	// ==========================================================================

	T mem [FIFO_DEPTH];    // payload only, not cleared

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;    // occupancy
	logic do_wr;
	logic do_rd;

	// drop writes when full and reads when empty
	assign do_wr = wr_i && !full_o;
	assign do_rd = rd_i && !empty_o;

	assign full_o  = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty_o = (count == '0);

	// first word fall through
	assign dout_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din_i;
		end
	end

	// ==========================================================================
	// control
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				// wrap explicitly so a depth that is not a power of two works
				if (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				if (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/biu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module biu_lane (
	input  biu_pkg::mem_func_t              func_i,
	input  biu_pkg::mem_size_t              size_i,
	input  logic [2:0]                      ofs_i,       // byte offset in the bus word
	input  logic [biu_pkg::DAT_W-1:0]       st_dat_i,    // right justified store data
	output logic [biu_pkg::SEL_W-1:0]       sel_o,
	output logic [biu_pkg::DAT_W-1:0]       st_dat_o,    // store data in its lanes
	input  logic [biu_pkg::DAT_W-1:0]       ld_dat_i,    // raw bus word
	output logic [biu_pkg::DAT_W-1:0]       ld_res_o     // aligned and extended
);
	import biu_pkg::*;

	logic [2:0]       aofs;        // offset with the bits below the size cleared
	logic [SEL_W-1:0] sel_base;    // size wide run of ones at lane 0
	logic [DAT_W-1:0] ld_shift;
	logic             ext;         // sign extend

	// natural alignment, so the access never leaves the bus word
	always_comb begin
		case (size_i)
			SZ_BYTE: begin
				aofs     = ofs_i;
				sel_base = 8'h01;
			end
			SZ_WYDE: begin
				aofs     = {ofs_i[2:1], 1'b0};
				sel_base = 8'h03;
			end
			SZ_TETRA: begin
				aofs     = {ofs_i[2], 2'b00};
				sel_base = 8'h0F;
			end
			default: begin    // octa
				aofs     = 3'b000;
				sel_base = 8'hFF;
			end
		endcase
	end

	// store side
	assign sel_o    = sel_base << aofs;
	assign st_dat_o = st_dat_i << {aofs, 3'b000};    // bytes to bits

	// load side
	assign ld_shift = ld_dat_i >> {aofs, 3'b000};
	assign ext      = (func_i == MR_LOAD);    // loadz fills with zeros

	always_comb begin
		case (size_i)
			SZ_BYTE:  ld_res_o = {{(DAT_W-8){ext & ld_shift[7]}}, ld_shift[7:0]};
			SZ_WYDE:  ld_res_o = {{(DAT_W-16){ext & ld_shift[15]}}, ld_shift[15:0]};
			SZ_TETRA: ld_res_o = {{(DAT_W-32){ext & ld_shift[31]}}, ld_shift[31:0]};
			default:  ld_res_o = ld_shift;    // octa needs no extension
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/biu_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module biu_seq (
	input  logic                        clk,
	input  logic                        rst,
	// request fifo head
	input  biu_pkg::mem_req_t           req_i,
	input  logic                        req_empty_i,
	output logic                        req_rd_o,
	// segment check
	input  logic [biu_pkg::ADR_W-1:0]   limit_i,
	input  logic                        bounds_chk_i,
	// bus
	output biu_pkg::bus_out_t           bus_o,
	input  logic                        ack_i,
	input  logic [biu_pkg::DAT_W-1:0]   dat_i,
	// response fifo
	output biu_pkg::mem_resp_t          resp_o,
	output logic                        resp_wr_o,
	input  logic                        resp_full_i
);
	import biu_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,    // wait for a request
		ST_BUS  = 2'd1,    // strobe out, wait for ack
		ST_RESP = 2'd2,    // push the completed response
		ST_FLT  = 2'd3     // push the fault response
	} seq_state_t;

	seq_state_t state;

	mem_req_t  req_q;      // request being worked on
	mem_req_t  cur_req;    // lane inputs
	mem_resp_t resp_q;     // response under construction

	logic             sgb_flt;
	logic             unk_flt;
	logic             resp_go;
	logic [SEL_W-1:0] lane_sel;
	logic [DAT_W-1:0] lane_st_dat;
	logic [DAT_W-1:0] lane_ld_res;

	// ==========================================================================
	// request decode
	// ==========================================================================

	// pop in the same cycle the head is seen
	assign req_rd_o = (state == ST_IDLE) && !req_empty_i;

	assign sgb_flt = bounds_chk_i && (req_i.adr > limit_i);
	assign unk_flt = !(req_i.func inside {MR_LOAD, MR_LOADZ, MR_STORE});

	// one lane unit serves both directions
	// idle steers the fresh head, later states align the held request
	assign cur_req = (state == ST_IDLE) ? req_i : req_q;

	biu_lane u_lane (
		.func_i   (cur_req.func),
		.size_i   (cur_req.size),
		.ofs_i    (cur_req.adr[2:0]),
		.st_dat_i (cur_req.dat),
		.sel_o    (lane_sel),
		.st_dat_o (lane_st_dat),
		.ld_dat_i (dat_i),
		.ld_res_o (lane_ld_res)
	);

	// ==========================================================================
	// response side
	// ==========================================================================

	// write only while there is room
	assign resp_go   = ((state == ST_RESP) || (state == ST_FLT)) && !resp_full_i;
	assign resp_wr_o = resp_go;
	assign resp_o    = resp_q;

	// ==========================================================================
	// state machine
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			bus_o.cyc <= 1'b0;
			bus_o.stb <= 1'b0;
			bus_o.we  <= 1'b0;
			bus_o.sel <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_rd_o) begin
						req_q       <= req_i;
						resp_q.tid  <= req_i.tid;
						resp_q.res  <= '0;    // stores and faults return zero
						if (unk_flt || sgb_flt) begin
							// no bus cycle for a faulting request
							resp_q.cause   <= unk_flt ? FLT_UNK : FLT_SGB;
							resp_q.bad_adr <= req_i.adr;
							state          <= ST_FLT;
						end else begin
							resp_q.cause   <= FLT_NONE;
							resp_q.bad_adr <= '0;
							bus_o.cyc      <= 1'b1;
							bus_o.stb      <= 1'b1;
							bus_o.we       <= (req_i.func == MR_STORE);
							bus_o.sel      <= lane_sel;
							bus_o.adr      <= {req_i.adr[ADR_W-1:3], 3'b000};    // word address
							bus_o.dat      <= lane_st_dat;
							state          <= ST_BUS;
						end
					end
				end
				ST_BUS: begin
					// all bus fields hold until ack
					if (ack_i) begin
						bus_o.cyc <= 1'b0;
						bus_o.stb <= 1'b0;
						bus_o.we  <= 1'b0;
						bus_o.sel <= '0;
						if (req_q.func != MR_STORE)
							resp_q.res <= lane_ld_res;    // sample the bus word
						state <= ST_RESP;
					end
				end
				ST_RESP, ST_FLT: begin
					if (resp_go)
						state <= ST_IDLE;    // otherwise stall, nothing more is popped
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/biu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module biu_top (
	input  logic                        clk,
	input  logic                        rst,
	// cpu request side
	input  biu_pkg::mem_req_t           req_i,
	input  logic                        req_wr_i,
	output logic                        req_full_o,
	// cpu response side
	output biu_pkg::mem_resp_t          resp_o,
	input  logic                        resp_rd_i,
	output logic                        resp_empty_o,
	// segment check
	input  logic [biu_pkg::ADR_W-1:0]   limit_i,
	input  logic                        bounds_chk_i,
	// bus
	output biu_pkg::bus_out_t           bus_o,
	input  logic                        ack_i,
	input  logic [biu_pkg::DAT_W-1:0]   dat_i
);
	import biu_pkg::*;

	mem_req_t  req_head;     // fifo head into the sequencer
	logic      req_empty;
	logic      req_rd;
	mem_resp_t seq_resp;     // sequencer into the response fifo
	logic      resp_wr;
	logic      resp_full;

	// ==========================================================================
	// request fifo -> sequencer -> response fifo
	// ==========================================================================

	biu_fifo #(.T(mem_req_t)) u_req_fifo (
		.clk     (clk),
		.rst     (rst),
		.wr_i    (req_wr_i),
		.din_i   (req_i),
		.rd_i    (req_rd),
		.dout_o  (req_head),
		.full_o  (req_full_o),
		.empty_o (req_empty)
	);

	biu_seq u_seq (
		.clk          (clk),
		.rst          (rst),
		.req_i        (req_head),
		.req_empty_i  (req_empty),
		.req_rd_o     (req_rd),
		.limit_i      (limit_i),
		.bounds_chk_i (bounds_chk_i),
		.bus_o        (bus_o),
		.ack_i        (ack_i),
		.dat_i        (dat_i),
		.resp_o       (seq_resp),
		.resp_wr_o    (resp_wr),
		.resp_full_i  (resp_full)
	);

	biu_fifo #(.T(mem_resp_t)) u_resp_fifo (
		.clk     (clk),
		.rst     (rst),
		.wr_i    (resp_wr),
		.din_i   (seq_resp),
		.rd_i    (resp_rd_i),
		.dout_o  (resp_o),
		.full_o  (resp_full),    // back pressure into the sequencer
		.empty_o (resp_empty_o)
	);

endmodule

`default_nettype wire

// ==== tb/biu_seq_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module biu_seq_assert (
	input logic              clk,
	input logic              rst,
	input biu_pkg::bus_out_t bus_i,    // sequencer bus outputs
	input logic              ack_i
);

	// ==========================================================================
	// bus protocol rules
	// ==========================================================================

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
		bus_i.stb |-> bus_i.cyc)
		else $error("stb high while cyc is low");

	a_stb_sel: assert property (@(posedge clk) disable iff (rst)
		bus_i.stb |-> (bus_i.sel != '0))    // at least one lane
		else $error("stb high with no byte lane selected");

	// every field held until the slave acks
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(bus_i.stb && !ack_i) |=> $stable(bus_i))
		else $error("bus fields changed before ack");

	a_rst_idle: assert property (@(posedge clk) rst |=> !bus_i.cyc)
		else $error("cyc high in the cycle after reset");

endmodule

bind biu_seq biu_seq_assert u_seq_assert (.clk(clk), .rst(rst), .bus_i(bus_o), .ack_i(ack_i));

`default_nettype wire

// ==== tb/tb_biu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_biu_top;
	import biu_pkg::*;

	localparam int REQ_COUNT  = 33;     // requests over all tests
	localparam int REQ_CYCLES = 30;     // generous bound per request
	localparam int RESP_WAIT  = 100;    // cycles before a missing response is an error

	logic             clk = 1'b0;
	logic             rst = 1'b1;
	mem_req_t         req_i = '0;
	logic             req_wr_i = 1'b0;
	logic             req_full_o;
	mem_resp_t        resp_o;
	logic             resp_rd_i = 1'b0;
	logic             resp_empty_o;
	logic [ADR_W-1:0] limit_i = '0;
	logic             bounds_chk_i = 1'b0;
	bus_out_t         bus_o;
	logic             ack_i = 1'b0;    // from the memory model
	logic [DAT_W-1:0] dat_i = '0;

	logic [7:0] mem_b [256];    // bus memory, byte lanes
	logic [7:0] ref_b [256];    // what the memory should hold
	logic       waiting = 1'b0;
	logic [1:0] wait_left = '0;
	integer     seed = 32'h7ef2;
	int         cyc_cnt = 0;    // cycles with cyc high
	int         checks = 0;
	int         errors = 0;

	biu_top u_biu_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (bus_o.cyc)
			cyc_cnt <= cyc_cnt + 1;
	end

	// ==========================================================================
	// bus memory model, acks after 0 to 3 wait cycles
	// ==========================================================================

	function automatic logic [7:0] fill_byte(int a);
		return 8'(a) ^ 8'h5a;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			ack_i   <= 1'b0;
			waiting <= 1'b0;
			for (int a = 0; a < 256; a++)
				mem_b[a] <= fill_byte(a);
		end else if (ack_i) begin    // ack lasts one cycle
			ack_i   <= 1'b0;
			waiting <= 1'b0;
		end else if (bus_o.cyc && bus_o.stb) begin
			if (!waiting) begin
				waiting   <= 1'b1;
				wait_left <= 2'($random(seed));
			end else if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				for (int b = 0; b < 8; b++) begin
					if (bus_o.we && bus_o.sel[b])
						mem_b[{bus_o.adr[7:3], 3'(b)}] <= bus_o.dat[8*b +: 8];
					dat_i[8*b +: 8] <= mem_b[{bus_o.adr[7:3], 3'(b)}];
				end
				ack_i <= 1'b1;
			end
		end
	end

	// ==========================================================================
	// reference rules and checks
	// ==========================================================================

	// aligned store into the reference bytes
	function automatic void ref_store(mem_size_t s, logic [31:0] adr, logic [63:0] dat);
		int i;
		logic [7:0] base;
		base = adr[7:0] & ~8'((1 << s) - 1);
		for (i = 0; i < (1 << s); i++)
			ref_b[8'(base + i)] = dat[8*i +: 8];
	endfunction

	// aligned load, sign fill only for MR_LOAD
	function automatic logic [63:0] ref_load(mem_func_t f, mem_size_t s, logic [31:0] adr);
		int i;
		int nb;
		logic [7:0] base;
		logic [63:0] v;
		nb   = 1 << s;
		base = adr[7:0] & ~8'(nb - 1);
		v    = '0;
		for (i = 0; i < nb; i++)
			v[8*i +: 8] = ref_b[8'(base + i)];
		if (f == MR_LOAD && v[8*nb-1]) begin
			for (i = 8 * nb; i < 64; i++)
				v[i] = 1'b1;
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// one write strobe, ok is low when the request fifo was full
	task automatic send_req(input mem_func_t f, input mem_size_t s, input logic [3:0] tid,
			input logic [31:0] adr, input logic [63:0] dat, output logic ok);
		mem_req_t r;
		r = '{func: f, size: s, tid: tid, adr: adr, dat: dat};
		@(posedge clk);
		req_i    <= r;
		req_wr_i <= 1'b1;
		@(negedge clk);
		ok = !req_full_o;    // full at this point drops the write
		@(posedge clk);
		req_wr_i <= 1'b0;
	endtask

	task automatic get_resp(output mem_resp_t r);
		int n;
		n = 0;
		r = '0;
		@(negedge clk);
		while (resp_empty_o && n < RESP_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (resp_empty_o) begin
			$display("no response arrived within %0d cycles", RESP_WAIT);
			errors++;
		end else begin
			r = resp_o;    // head is valid while not empty
			@(posedge clk);
			resp_rd_i <= 1'b1;
			@(posedge clk);
			resp_rd_i <= 1'b0;
		end
	endtask

	task automatic run_access(input mem_func_t f, input mem_size_t s, input logic [3:0] tid,
			input logic [31:0] adr, input logic [63:0] dat, output mem_resp_t r);
		logic ok;
		send_req(f, s, tid, adr, dat, ok);
		if (!ok) begin
			$display("request tid %0d was dropped by a full request FIFO", tid);
			errors++;
		end
		get_resp(r);
	endtask

	task automatic store_and_verify(input mem_size_t s, input logic [31:0] adr,
			input logic [63:0] dat, input logic [3:0] tid);
		mem_resp_t r;
		run_access(MR_STORE, s, tid, adr, dat, r);
		ref_store(s, adr, dat);
		check("store tid", 64'(tid), 64'(r.tid));
		check("store cause", 64'(FLT_NONE), 64'(r.cause));
		check("store res", 64'd0, r.res);
		run_access(MR_LOAD, SZ_OCTA, tid + 4'd1, adr, 64'd0, r);    // read back whole word
		check("store merged word", ref_load(MR_LOAD, SZ_OCTA, adr), r.res);
	endtask

	task automatic load_and_verify(input mem_func_t f, input mem_size_t s,
			input logic [3:0] tid, input logic [31:0] adr);
		mem_resp_t r;
		run_access(f, s, tid, adr, 64'd0, r);
		check("extend tid", 64'(tid), 64'(r.tid));
		check("extend res", ref_load(f, s, adr), r.res);
	endtask

	// ==========================================================================
	// directed tests
	// ==========================================================================

	task automatic reset_test();
		@(negedge clk);
		check("reset cyc", 64'd0, 64'(bus_o.cyc));
		check("reset stb", 64'd0, 64'(bus_o.stb));
		check("reset resp_empty", 64'd1, 64'(resp_empty_o));
		check("reset req_full", 64'd0, 64'(req_full_o));
	endtask

	task automatic store_merge_test();
		store_and_verify(SZ_BYTE,  32'h40, 64'h0000_0000_0000_00c1, 4'd0);
		store_and_verify(SZ_BYTE,  32'h45, 64'h0000_0000_0000_00c2, 4'd2);
		store_and_verify(SZ_WYDE,  32'h42, 64'h0000_0000_0000_d3e4, 4'd4);
		store_and_verify(SZ_WYDE,  32'h4f, 64'h0000_0000_0000_a5b6, 4'd6);    // offset 7 to 6
		store_and_verify(SZ_TETRA, 32'h4c, 64'h0000_0000_1357_9bdf, 4'd8);
		store_and_verify(SZ_TETRA, 32'h51, 64'h0000_0000_2468_ace0, 4'd10);   // offset 1 to 0
		store_and_verify(SZ_OCTA,  32'h5b, 64'h0f1e_2d3c_4b5a_6978, 4'd12);
	endtask

	task automatic extend_test();
		mem_resp_t r;
		int fi;
		int si;
		run_access(MR_STORE, SZ_OCTA, 4'd1, 32'h60, 64'h8877_f6e5_d4c3_b2a1, r);
		ref_store(SZ_OCTA, 32'h60, 64'h8877_f6e5_d4c3_b2a1);
		// byte at 1, wyde at 2, tetra at 4, all with the top bit set
		for (fi = 0; fi < 2; fi++) begin
			for (si = 0; si < 3; si++)
				load_and_verify(mem_func_t'(2'(fi)), mem_size_t'(2'(si)), 4'(2 + fi * 3 + si),
					32'h60 + 32'(1 << si));
		end
	endtask

	task automatic bounds_test();
		mem_resp_t r;
		int cyc_before;
		@(posedge clk);
		limit_i      <= 32'h0000_00ff;
		bounds_chk_i <= 1'b1;
		cyc_before = cyc_cnt;
		run_access(MR_LOAD, SZ_TETRA, 4'd5, 32'h0000_0148, 64'd0, r);
		check("bounds cause", 64'(FLT_SGB), 64'(r.cause));
		check("bounds bad_adr", 64'h148, 64'(r.bad_adr));
		check("bounds res", 64'd0, r.res);
		check("bounds no cyc", 64'(cyc_before), 64'(cyc_cnt));
		@(posedge clk);
		bounds_chk_i <= 1'b0;
		run_access(MR_LOAD, SZ_TETRA, 4'd6, 32'h0000_0148, 64'd0, r);
		check("unchecked cause", 64'(FLT_NONE), 64'(r.cause));
		check("unchecked res", ref_load(MR_LOAD, SZ_TETRA, 32'h148), r.res);
		check("unchecked cyc seen", 64'd1, 64'(cyc_cnt > cyc_before));
	endtask

	task automatic backpressure_test();
		int acc_q[$];    // indices that got into the fifo
		mem_resp_t r;
		logic ok;
		logic full_seen;
		int i;
		full_seen = 1'b0;
		for (i = 0; i < 2 * FIFO_DEPTH + 2; i++) begin
			send_req(MR_LOADZ, SZ_OCTA, 4'(i), 32'(i * 8), 64'd0, ok);
			if (ok)
				acc_q.push_back(i);
			else
				full_seen = 1'b1;
		end
		check("backpressure req_full", 64'd1, 64'(full_seen));
		while (acc_q.size() > 0) begin
			i = acc_q.pop_front();
			get_resp(r);
			check("backpressure tid", 64'(4'(i)), 64'(r.tid));
			check("backpressure res", ref_load(MR_LOADZ, SZ_OCTA, 32'(i * 8)), r.res);
		end
	endtask

	// ==========================================================================
	// sequence and watchdog
	// ==========================================================================

	initial begin
		for (int a = 0; a < 256; a++)
			ref_b[a] = fill_byte(a);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		reset_test();
		store_merge_test();
		extend_test();
		bounds_test();
		backpressure_test();
		repeat (4) @(posedge clk);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		repeat (16 + REQ_COUNT * REQ_CYCLES) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== biu_top.f ====
hdl/biu_pkg.sv
hdl/biu_fifo.sv
hdl/biu_lane.sv
hdl/biu_seq.sv
hdl/biu_top.sv
tb/biu_seq_assert.sv
tb/tb_biu_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the biu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_biu_top -f biu_top.f \
	-o sim_biu > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_biu > sim.log 2>&1
cat sim.log
# the log decides, the exit status of the model is not trusted
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
